// File: hw/snd_pkg.sv
// Sound device shared definitions
package snd_pkg;

    // Number of tone voice slots on the I/O bus
    localparam int NUM_VOICES = 3;

    // Device-type code that addresses this device on the management bus
    localparam logic [7:0] DEV_TYPE_SOUND = 8'h0B;

    // Register indices reached through the index/data pair
    localparam logic [7:0] REG_FREQ_LO = 8'h10;
    localparam logic [7:0] REG_CTRL = 8'h20;

    // Phase accumulator width, the top bit gives the square-wave sign
    localparam int PHASE_BITS = 20;

    // Width of one voice sample and of the mixer output
    localparam int SAMPLE_BITS = 16;

    // Headroom for summing all voices before the clamp
    localparam int SUM_BITS = SAMPLE_BITS + $clog2(NUM_VOICES);

    // Output level for one step of the 4-bit volume
    localparam logic [SAMPLE_BITS-1:0] AMP_STEP = 16'd2048;

    // One data byte, seen either as the low frequency byte or as the control byte.
    // Which view applies depends on the index latched before the data write
    typedef union packed {
        logic [7:0] freq_lo;
        struct packed {
            logic       key_on;
            logic [2:0] block;
            logic [1:0] freq_hi;
            logic [1:0] reserved;
        } ctrl;
    } voice_reg_u;

endpackage

// File: hw/io_decode.sv
// Sound device I/O decoder
`timescale 1ns/1ps

module io_decode
    import snd_pkg::*;
(
    input  logic                        cpu_bus,
    input  logic                        rst_n,
    // CPU I/O cycle
    input  logic                        iorq,
    input  logic                        m1,
    input  logic                        wr,
    input  logic                        req,
    input  logic [7:0]                  addr,
    input  logic [7:0]                  data,
    // Device-management bus
    input  logic [7:0]                  dev_typ,
    input  logic [1:0]                  dev_num,
    input  logic                        dev_en,
    input  logic                        dev_we,
    // Per-slot port configuration
    input  logic [NUM_VOICES-1:0]       io_enable,
    input  logic [NUM_VOICES-1:0][7:0]  io_port,
    input  logic [NUM_VOICES-1:0][7:0]  io_mask,
    // Towards the voices and the mixer
    output logic [NUM_VOICES-1:0]       voice_wr,
    output logic                        reg_sel,
    output logic [7:0]                  wr_data,
    output logic [NUM_VOICES-1:0]       audible_mask
);

    // A plain CPU I/O write, opcode fetches never count as port accesses
    logic cpu_wr;
    // Management bus is talking to a sound device
    logic dev_sel_typ;
    // Management cycle that updates a slot enable bit rather than writing
    logic dev_cfg;
    // Slot enable bits owned by the management bus
    logic [NUM_VOICES-1:0] slot_en;
    // Per-slot hits from each bus side
    logic [NUM_VOICES-1:0] cpu_hit;
    logic [NUM_VOICES-1:0] dev_hit;
    logic [NUM_VOICES-1:0] wr_hit;

    assign cpu_wr = iorq && wr && req && !m1;
    assign dev_sel_typ = (dev_typ == DEV_TYPE_SOUND);
    assign dev_cfg = dev_sel_typ && !dev_we && (int'(dev_num) < NUM_VOICES);

    genvar i;
    generate
        for (i = 0; i < NUM_VOICES; i++) begin : gen_slot
            // CPU side needs the slot configured, enabled and the masked port to match
            assign cpu_hit[i] = cpu_wr && io_enable[i] && slot_en[i] &&
                                ((addr & io_mask[i]) == io_port[i]);
            // The management bus reaches the slot directly, even when it is disabled
            assign dev_hit[i] = dev_sel_typ && dev_we && (int'(dev_num) == i);
        end
    endgenerate

    assign wr_hit = cpu_hit | dev_hit;

    // Strobes, slot enables and the audible mask are control state
    always_ff @(posedge cpu_bus or negedge rst_n) begin
        if (!rst_n) begin
            voice_wr <= '0;
            slot_en <= '1;
            audible_mask <= '0;
        end else begin
            voice_wr <= wr_hit;
            audible_mask <= io_enable;
            if (dev_cfg) begin
                slot_en[dev_num] <= dev_en;
            end
        end
    end

    // Address bit 0 picks index or data, both bus sides share the CPU data lines.
    // Only captured when some slot is written so the voices see a stable byte
    always_ff @(posedge cpu_bus) begin
        if (|wr_hit) begin
            reg_sel <= addr[0];
            wr_data <= data;
        end
    end

endmodule

// File: hw/tone_voice.sv
// Square-wave tone voice
`timescale 1ns/1ps

module tone_voice
    import snd_pkg::*;
(
    input  logic                          cpu_bus,
    input  logic                          rst_n,
    input  logic                          sample_ce,
    input  logic                          wr,
    input  logic                          reg_sel,
    input  logic [7:0]                    wr_data,
    output logic signed [SAMPLE_BITS-1:0] sample
);

    // Incoming byte decoded through the register union
    voice_reg_u wr_word;
    // Index latched by the last write with reg_sel low
    logic [7:0] reg_idx;
    // Tone registers
    logic [9:0] freq_num;
    logic [2:0] block;
    logic       key_on;
    logic [3:0] volume;
    // Phase accumulator and its per-sample step
    logic [PHASE_BITS-1:0] phase;
    logic [PHASE_BITS-1:0] phase_inc;
    // Write decode
    logic data_wr;
    logic freq_lo_wr;
    logic ctrl_wr;
    logic vol_wr;
    logic key_start;
    // Magnitude of the square wave
    logic signed [SAMPLE_BITS-1:0] amp;

    assign wr_word = wr_data;

    assign data_wr = wr && reg_sel;
    assign freq_lo_wr = data_wr && (reg_idx == REG_FREQ_LO);
    assign ctrl_wr = data_wr && (reg_idx == REG_CTRL);
    // Volume sits on the index right after the control byte
    assign vol_wr = data_wr && (reg_idx == REG_CTRL + 8'd1);

    // Writing the control byte with key_on set restarts the wave at phase 0
    assign key_start = ctrl_wr && wr_word.ctrl.key_on;

    // Index latch
    always_ff @(posedge cpu_bus or negedge rst_n) begin
        if (!rst_n) begin
            reg_idx <= '0;
        end else if (wr && !reg_sel) begin
            reg_idx <= wr_data;
        end
    end

    // Frequency number is split over the low byte and the control byte
    always_ff @(posedge cpu_bus or negedge rst_n) begin
        if (!rst_n) begin
            freq_num <= '0;
        end else if (freq_lo_wr) begin
            freq_num[7:0] <= wr_word.freq_lo;
        end else if (ctrl_wr) begin
            freq_num[9:8] <= wr_word.ctrl.freq_hi;
        end
    end

    // Control byte fields, the reserved bits are dropped
    always_ff @(posedge cpu_bus or negedge rst_n) begin
        if (!rst_n) begin
            key_on <= 1'b0;
            block <= '0;
        end else if (ctrl_wr) begin
            key_on <= wr_word.ctrl.key_on;
            block <= wr_word.ctrl.block;
        end
    end

    // Only the low nibble of the volume byte is kept
    always_ff @(posedge cpu_bus or negedge rst_n) begin
        if (!rst_n) begin
            volume <= '0;
        end else if (vol_wr) begin
            volume <= wr_data[3:0];
        end
    end

    // Block acts as an octave shift on the frequency number.
    // At most 17 bits wide, so the shift never leaves the accumulator
    assign phase_inc = PHASE_BITS'(freq_num) << block;

    // Key-on wins over a sample step landing on the same edge
    always_ff @(posedge cpu_bus or negedge rst_n) begin
        if (!rst_n) begin
            phase <= '0;
        end else if (key_start) begin
            phase <= '0;
        end else if (sample_ce) begin
            phase <= phase + phase_inc;
        end
    end

    // Fifteen steps of 2048 stay below the positive limit
    assign amp = SAMPLE_BITS'(volume) * AMP_STEP;

    // First half of the period is positive, second half negative
    always_comb begin
        if (!key_on) begin
            sample = '0;
        end else if (phase[PHASE_BITS-1]) begin
            sample = -amp;
        end else begin
            sample = amp;
        end
    end

endmodule

// File: hw/voice_mixer.sv
// Saturating voice mixer
`timescale 1ns/1ps

module voice_mixer
    import snd_pkg::*;
(
    input  logic                          cpu_bus,
    input  logic                          rst_n,
    input  logic [NUM_VOICES-1:0]         audible_mask,
    input  logic signed [SAMPLE_BITS-1:0] voice_sample [NUM_VOICES],
    output logic signed [SAMPLE_BITS-1:0] sound
);

    // Full-width sum, wide enough for every voice at either extreme
    logic signed [SUM_BITS-1:0] sum;
    // Bits above the output sign, all equal when the sum fits
    logic [SUM_BITS-SAMPLE_BITS:0] sum_top;
    logic in_range;
    logic signed [SAMPLE_BITS-1:0] clamped;

    // Muted slots contribute nothing, the samples are sign-extended before adding
    always_comb begin
        sum = '0;
        for (int i = 0; i < NUM_VOICES; i++) begin
            if (audible_mask[i]) begin
                sum = sum + SUM_BITS'(voice_sample[i]);
            end
        end
    end

    assign sum_top = sum[SUM_BITS-1:SAMPLE_BITS-1];
    assign in_range = (sum_top == '0) || (sum_top == '1);

    // Out of range goes to the limit on the side of the sum's sign
    always_comb begin
        if (in_range) begin
            clamped = sum[SAMPLE_BITS-1:0];
        end else if (sum[SUM_BITS-1]) begin
            clamped = {1'b1, {(SAMPLE_BITS-1){1'b0}}};
        end else begin
            clamped = {1'b0, {(SAMPLE_BITS-1){1'b1}}};
        end
    end

    // Registered output level, silent out of reset
    always_ff @(posedge cpu_bus or negedge rst_n) begin
        if (!rst_n) begin
            sound <= '0;
        end else begin
            sound <= clamped;
        end
    end

endmodule

// File: hw/sound_device.sv
// Three-voice sound device
`timescale 1ns/1ps

module sound_device
    import snd_pkg::*;
(
    input  logic                          cpu_bus,
    input  logic                          rst_n,
    // CPU I/O cycle
    input  logic                          iorq,
    input  logic                          m1,
    input  logic                          wr,
    input  logic                          req,
    input  logic [7:0]                    addr,
    input  logic [7:0]                    data,
    // Device-management bus
    input  logic [7:0]                    dev_typ,
    input  logic [1:0]                    dev_num,
    input  logic                          dev_en,
    input  logic                          dev_we,
    // Per-slot port configuration
    input  logic [NUM_VOICES-1:0]         io_enable,
    input  logic [NUM_VOICES-1:0][7:0]    io_port,
    input  logic [NUM_VOICES-1:0][7:0]    io_mask,
    // Sample clock enable for the phase accumulators
    input  logic                          sample_ce,
    // Mixed output level
    output logic signed [SAMPLE_BITS-1:0] sound
);

    // Decoder to voices
    logic [NUM_VOICES-1:0] voice_wr;
    logic                  reg_sel;
    logic [7:0]            wr_data;
    // Decoder to mixer, the mixer only sees the registered enables
    logic [NUM_VOICES-1:0] audible_mask;
    // One level per voice
    logic signed [SAMPLE_BITS-1:0] voice_sample [NUM_VOICES];

    io_decode u_decode (
        .cpu_bus      (cpu_bus),
        .rst_n        (rst_n),
        .iorq         (iorq),
        .m1           (m1),
        .wr           (wr),
        .req          (req),
        .addr         (addr),
        .data         (data),
        .dev_typ      (dev_typ),
        .dev_num      (dev_num),
        .dev_en       (dev_en),
        .dev_we       (dev_we),
        .io_enable    (io_enable),
        .io_port      (io_port),
        .io_mask      (io_mask),
        .voice_wr     (voice_wr),
        .reg_sel      (reg_sel),
        .wr_data      (wr_data),
        .audible_mask (audible_mask)
    );

    // Every voice shares the register byte and select, only the strobe differs
    genvar i;
    generate
        for (i = 0; i < NUM_VOICES; i++) begin : gen_voice
            tone_voice u_voice (
                .cpu_bus   (cpu_bus),
                .rst_n     (rst_n),
                .sample_ce (sample_ce),
                .wr        (voice_wr[i]),
                .reg_sel   (reg_sel),
                .wr_data   (wr_data),
                .sample    (voice_sample[i])
            );
        end
    endgenerate

    voice_mixer u_mix (
        .cpu_bus      (cpu_bus),
        .rst_n        (rst_n),
        .audible_mask (audible_mask),
        .voice_sample (voice_sample),
        .sound        (sound)
    );

endmodule

// File: verification/sound_device_sva.sv
// Decoder assertions
`timescale 1ns/1ps

module io_decode_sva
    import snd_pkg::*;
(
    input logic                  cpu_bus,
    input logic                  rst_n,
    input logic [7:0]            dev_typ,
    input logic [1:0]            dev_num,
    input logic                  dev_we,
    input logic [NUM_VOICES-1:0] io_enable,
    input logic [NUM_VOICES-1:0] slot_en,
    input logic [NUM_VOICES-1:0] voice_wr,
    input logic [NUM_VOICES-1:0] audible_mask
);

    // Strobes leave reset idle
    assert property (@(posedge cpu_bus) $rose(rst_n) |-> (voice_wr == '0))
        else $error("voice_wr active when reset was released");

    // A disabled slot is reachable only from the management bus
    genvar i;
    generate
        for (i = 0; i < NUM_VOICES; i++) begin : gen_slot
            assert property (@(posedge cpu_bus) disable iff (!rst_n)
                (voice_wr[i] && !$past(slot_en[i])) |->
                    $past((dev_typ == DEV_TYPE_SOUND) && dev_we && (dev_num == 2'(i))))
                else $error("slot %0d strobed while disabled without a device-bus write", i);
        end
    endgenerate

    // The mixer gate is io_enable delayed by one clock
    assert property (@(posedge cpu_bus) disable iff (!rst_n)
        $past(rst_n) |-> (audible_mask == $past(io_enable)))
        else $error("audible_mask differs from io_enable of the previous cycle");

endmodule

bind io_decode io_decode_sva u_sva (
    .cpu_bus      (cpu_bus),
    .rst_n        (rst_n),
    .dev_typ      (dev_typ),
    .dev_num      (dev_num),
    .dev_we       (dev_we),
    .io_enable    (io_enable),
    .slot_en      (slot_en),
    .voice_wr     (voice_wr),
    .audible_mask (audible_mask)
);

// File: verification/sound_device_tb.sv
// Sound device testbench
`timescale 1ns/1ps

module sound_device_tb
    import snd_pkg::*;
();

    logic                          cpu_bus = 1'b0;
    logic                          rst_n;
    logic                          iorq;
    logic                          m1;
    logic                          wr;
    logic                          req;
    logic [7:0]                    addr;
    logic [7:0]                    data;
    logic [7:0]                    dev_typ;
    logic [1:0]                    dev_num;
    logic                          dev_en;
    logic                          dev_we;
    logic [NUM_VOICES-1:0]         io_enable;
    logic [NUM_VOICES-1:0][7:0]    io_port;
    logic [NUM_VOICES-1:0][7:0]    io_mask;
    logic                          sample_ce;
    logic signed [SAMPLE_BITS-1:0] sound;

    integer seed;
    int     err_count = 0;
    int     check_count = 0;
    int     tests_run = 0;
    int     tests_bad = 0;
    int     test_err_start = 0;

    // Model of the decoder stage, the slot enables and the audible mask
    logic [NUM_VOICES-1:0]                  m_strobe;
    logic                                   m_reg_sel;
    logic [7:0]                             m_wr_data;
    logic [NUM_VOICES-1:0]                  m_slot_en;
    logic [NUM_VOICES-1:0]                  m_audible;
    // Model of the voice registers and phases
    logic [NUM_VOICES-1:0][7:0]             m_idx;
    logic [NUM_VOICES-1:0][9:0]             m_freq;
    logic [NUM_VOICES-1:0][2:0]             m_block;
    logic [NUM_VOICES-1:0]                  m_key;
    logic [NUM_VOICES-1:0][3:0]             m_vol;
    logic [NUM_VOICES-1:0][PHASE_BITS-1:0]  m_phase;

    sound_device u_dut (.*);

    always #20 cpu_bus = ~cpu_bus;

    // Clamped sum of the audible keyed voices with each sign taken from the phase top bit
    function automatic int expected_sound(
        input logic [NUM_VOICES-1:0]                 key,
        input logic [NUM_VOICES-1:0][3:0]            vol,
        input logic [NUM_VOICES-1:0][PHASE_BITS-1:0] phase,
        input logic [NUM_VOICES-1:0]                 audible
    );
        int total;
        int level;
        total = 0;
        for (int i = 0; i < NUM_VOICES; i++) begin
            level = int'(vol[i]) * int'(AMP_STEP);
            if (audible[i] && key[i]) begin
                total = phase[i][PHASE_BITS-1] ? total - level : total + level;
            end
        end
        if (total > 32767) begin
            return 32767;
        end else if (total < -32768) begin
            return -32768;
        end
        return total;
    endfunction

    task automatic reset_model();
        m_strobe = '0;
        m_reg_sel = 1'b0;
        m_wr_data = '0;
        m_slot_en = '1;
        m_audible = '0;
        m_idx = '0;
        m_freq = '0;
        m_block = '0;
        m_key = '0;
        m_vol = '0;
        m_phase = '0;
    endtask

    // One clock edge of the model where every update reads the values from before the edge
    task automatic advance_model();
        logic [NUM_VOICES-1:0] hit;
        logic [PHASE_BITS-1:0] inc;
        logic                  key_start;
        logic                  cpu_ok;
        logic                  dev_sel;
        voice_reg_u            w;
        w = m_wr_data;
        // Voices act on the strobes captured one edge earlier
        for (int i = 0; i < NUM_VOICES; i++) begin
            inc = {10'b0, m_freq[i]} << m_block[i];
            key_start = 1'b0;
            if (m_strobe[i] && !m_reg_sel) begin
                m_idx[i] = m_wr_data;
            end else if (m_strobe[i]) begin
                case (m_idx[i])
                    REG_FREQ_LO: m_freq[i][7:0] = w.freq_lo;
                    REG_CTRL: begin
                        m_freq[i][9:8] = w.ctrl.freq_hi;
                        m_block[i] = w.ctrl.block;
                        m_key[i] = w.ctrl.key_on;
                        key_start = w.ctrl.key_on;
                    end
                    REG_CTRL + 8'd1: m_vol[i] = m_wr_data[3:0];
                    default: ;
                endcase
            end
            if (key_start) begin
                m_phase[i] = '0;
            end else if (sample_ce) begin
                m_phase[i] = m_phase[i] + inc;
            end
        end
        // Decoder stage from the bus inputs at this edge
        cpu_ok = iorq && wr && req && !m1;
        dev_sel = (dev_typ == DEV_TYPE_SOUND);
        for (int i = 0; i < NUM_VOICES; i++) begin
            hit[i] = (cpu_ok && io_enable[i] && m_slot_en[i] &&
                      ((addr & io_mask[i]) == io_port[i])) ||
                     (dev_sel && dev_we && int'(dev_num) == i);
        end
        if (|hit) begin
            m_reg_sel = addr[0];
            m_wr_data = data;
        end
        m_strobe = hit;
        if (dev_sel && !dev_we && int'(dev_num) < NUM_VOICES) begin
            m_slot_en[dev_num] = dev_en;
        end
        m_audible = io_enable;
    endtask

    // Sound registers the level of the state held before each edge
    always @(posedge cpu_bus) begin
        int exp_now;
        if (!rst_n) begin
            reset_model();
            exp_now = 0;
        end else begin
            exp_now = expected_sound(m_key, m_vol, m_phase, m_audible);
            advance_model();
        end
        #1;
        check_count++;
        assert (int'(sound) == exp_now) else begin
            $display("Fail at %0t: sound = %0d, expected %0d", $time, sound, exp_now);
            err_count++;
        end
    end

    task automatic check_value(input string what, input int got, input int exp);
        check_count++;
        assert (got == exp) else begin
            $display("Fail at %0t: %s = %0d, expected %0d", $time, what, got, exp);
            err_count++;
        end
    endtask

    task automatic io_cycle(input logic [7:0] a, input logic [7:0] d,
                            input logic m1_v, input logic req_v);
        @(negedge cpu_bus);
        iorq = 1'b1;
        wr = 1'b1;
        m1 = m1_v;
        req = req_v;
        addr = a;
        data = d;
        @(negedge cpu_bus);
        iorq = 1'b0;
        wr = 1'b0;
        m1 = 1'b0;
        req = 1'b0;
    endtask

    task automatic io_write(input logic [7:0] a, input logic [7:0] d);
        io_cycle(a, d, 1'b0, 1'b1);
    endtask

    // Management write where address bit 0 still picks index or data
    task automatic dev_write(input logic [1:0] num, input logic sel, input logic [7:0] d);
        @(negedge cpu_bus);
        dev_typ = DEV_TYPE_SOUND;
        dev_we = 1'b1;
        dev_num = num;
        addr = {7'b0, sel};
        data = d;
        @(negedge cpu_bus);
        dev_typ = 8'h00;
        dev_we = 1'b0;
    endtask

    task automatic dev_config(input logic [1:0] num, input logic en);
        @(negedge cpu_bus);
        dev_typ = DEV_TYPE_SOUND;
        dev_we = 1'b0;
        dev_num = num;
        dev_en = en;
        @(negedge cpu_bus);
        dev_typ = 8'h00;
    endtask

    task automatic set_reg(input int slot, input logic [7:0] idx, input logic [7:0] value);
        io_write(io_port[slot], idx);
        io_write(io_port[slot] | 8'h01, value);
    endtask

    function automatic logic [7:0] ctrl_byte(input logic key, input logic [2:0] blk,
                                             input logic [1:0] fhi);
        voice_reg_u w;
        w.ctrl.key_on = key;
        w.ctrl.block = blk;
        w.ctrl.freq_hi = fhi;
        w.ctrl.reserved = 2'b00;
        return w;
    endfunction

    // Key-on comes last so the level appears two cycles after the control write
    task automatic setup_voice(input int slot, input logic [9:0] freq, input logic [2:0] blk,
                               input logic [3:0] vol);
        set_reg(slot, REG_FREQ_LO, freq[7:0]);
        set_reg(slot, REG_CTRL + 8'd1, {4'b0, vol});
        set_reg(slot, REG_CTRL, ctrl_byte(1'b1, blk, freq[9:8]));
    endtask

    task automatic mute_voice(input int slot);
        set_reg(slot, REG_CTRL, ctrl_byte(1'b0, 3'd0, 2'd0));
    endtask

    task automatic wait_sound(input int target, input int limit, input string what);
        int n;
        n = 0;
        while (int'(sound) != target && n < limit) begin
            @(negedge cpu_bus);
            n++;
        end
        check_count++;
        assert (int'(sound) == target) else begin
            $display("Timed out after %0d cycles waiting for sound to reach %0d in %s",
                     limit, target, what);
            err_count++;
        end
    endtask

    task automatic idle_cycles(input int n);
        for (int k = 0; k < n; k++) begin
            @(negedge cpu_bus);
        end
    endtask

    task automatic start_test();
        test_err_start = err_count;
    endtask

    task automatic finish_test(input string name);
        int errs;
        errs = err_count - test_err_start;
        tests_run++;
        if (errs != 0) begin
            tests_bad++;
        end
        $display("Test %0d %s: %0d errors", tests_run, name, errs);
    endtask

    initial begin : watchdog
        for (int n = 0; n < 20000; n++) begin
            @(posedge cpu_bus);
        end
        $display("Global timeout, the test sequence never reached its end");
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        int         pulses;
        int         prev_pulses;
        int         n;
        logic [31:0] rnd;
        logic       flipped;
        seed = 32'h33e83a88;
        rst_n = 1'b0;
        iorq = 1'b0;
        m1 = 1'b0;
        wr = 1'b0;
        req = 1'b0;
        addr = '0;
        data = '0;
        dev_typ = 8'h00;
        dev_num = '0;
        dev_en = 1'b0;
        dev_we = 1'b0;
        sample_ce = 1'b0;
        io_enable = '1;
        io_port[0] = 8'h40;
        io_port[1] = 8'h50;
        io_port[2] = 8'h60;
        io_mask = {NUM_VOICES{8'hFE}};
        repeat (5) @(posedge cpu_bus);
        @(negedge cpu_bus);
        rst_n = 1'b1;

        start_test();
        idle_cycles(10);
        check_value("sound after reset", int'(sound), 0);
        finish_test("idle after reset");

        // Each voice alone with frequency 0 so the level stays constant and positive
        start_test();
        for (int s = 0; s < NUM_VOICES; s++) begin
            setup_voice(s, 10'd0, 3'd0, 4'(5 + 4 * s));
            @(negedge cpu_bus);
            check_value("sound one cycle after key-on", int'(sound), 0);
            @(negedge cpu_bus);
            check_value("sound two cycles after key-on", int'(sound),
                        (5 + 4 * s) * int'(AMP_STEP));
            mute_voice(s);
            wait_sound(0, 10, "key-off");
        end
        finish_test("key-on level per voice");

        // Increment 256 << 2 reaches the phase midpoint after 512 pulses
        start_test();
        setup_voice(0, 10'h100, 3'd2, 4'd8);
        wait_sound(8 * int'(AMP_STEP), 10, "key-on before sign test");
        pulses = 0;
        prev_pulses = 0;
        flipped = 1'b0;
        n = 0;
        while (!flipped && n < 4000) begin
            @(negedge cpu_bus);
            n++;
            if (int'(sound) < 0) begin
                flipped = 1'b1;
            end else begin
                // Sound lags the pulse count by one drive step
                prev_pulses = pulses;
                rnd = $random(seed);
                sample_ce = rnd[0];
                if (rnd[0]) begin
                    pulses++;
                end
            end
        end
        sample_ce = 1'b0;
        check_count++;
        assert (flipped) else begin
            $display("Timed out after 4000 cycles waiting for the level to turn negative");
            err_count++;
        end
        check_value("sample_ce pulses to sign flip", prev_pulses, 512);
        mute_voice(0);
        wait_sound(0, 10, "key-off after sign test");
        finish_test("sign follows phase");

        // Three loud voices clamp at both limits
        start_test();
        for (int s = 0; s < NUM_VOICES; s++) begin
            setup_voice(s, 10'h3FF, 3'd7, 4'd15);
        end
        wait_sound(32767, 10, "positive saturation");
        for (int k = 0; k < 5; k++) begin
            @(negedge cpu_bus);
            sample_ce = 1'b1;
        end
        @(negedge cpu_bus);
        sample_ce = 1'b0;
        wait_sound(-32768, 10, "negative saturation");
        for (int s = 0; s < NUM_VOICES; s++) begin
            mute_voice(s);
        end
        wait_sound(0, 10, "key-off after saturation");
        finish_test("saturation");

        start_test();
        setup_voice(1, 10'd0, 3'd0, 4'd6);
        wait_sound(6 * int'(AMP_STEP), 10, "masking setup");
        // Addresses that miss every masked port
        io_write(8'h52, REG_CTRL + 8'd1);
        io_write(8'h53, 8'h0F);
        io_write(8'h71, 8'h0F);
        idle_cycles(4);
        check_value("sound after missed writes", int'(sound), 6 * int'(AMP_STEP));
        // Disabled slot ignores the CPU but not the management bus
        dev_config(2'd1, 1'b0);
        set_reg(1, REG_CTRL + 8'd1, 8'h0F);
        idle_cycles(4);
        check_value("sound after write to disabled slot", int'(sound), 6 * int'(AMP_STEP));
        dev_write(2'd1, 1'b0, REG_CTRL + 8'd1);
        dev_write(2'd1, 1'b1, 8'h0F);
        wait_sound(15 * int'(AMP_STEP), 10, "device-bus write");
        dev_config(2'd1, 1'b1);
        @(negedge cpu_bus);
        io_enable[1] = 1'b0;
        wait_sound(0, 10, "io_enable cleared");
        io_enable[1] = 1'b1;
        wait_sound(15 * int'(AMP_STEP), 10, "io_enable restored");
        mute_voice(1);
        wait_sound(0, 10, "key-off after masking");
        finish_test("port masking and slot enables");

        start_test();
        setup_voice(2, 10'd0, 3'd0, 4'd4);
        wait_sound(4 * int'(AMP_STEP), 10, "bus qualifier setup");
        io_write(8'h60, REG_CTRL + 8'd1);
        io_cycle(8'h61, 8'h0F, 1'b1, 1'b1);
        io_cycle(8'h61, 8'h0F, 1'b0, 1'b0);
        idle_cycles(4);
        check_value("sound after m1 and req-less writes", int'(sound), 4 * int'(AMP_STEP));
        io_write(8'h61, 8'h02);
        wait_sound(2 * int'(AMP_STEP), 10, "qualified write");
        finish_test("m1 and req qualifiers");

        idle_cycles(2);
        $display("Tests run %0d, tests with errors %0d, checks %0d, errors %0d",
                 tests_run, tests_bad, check_count, err_count);
        if (err_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: flist.f
hw/snd_pkg.sv
hw/io_decode.sv
hw/tone_voice.sv
hw/voice_mixer.sv
hw/sound_device.sv
verification/sound_device_sva.sv
verification/sound_device_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line in the log
cd "$(dirname "$0")" || exit 1
LOG=sim.log
rm -f "$LOG"
verilator --binary --timing --assert --top-module sound_device_tb -f flist.f \
    && ./obj_dir/Vsound_device_tb > "$LOG" 2>&1 \
    || { cat "$LOG" 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }
cat "$LOG"
grep -q "Simulation PASSED" "$LOG" && exit 0 || exit 1
